// File: src/dcache_pkg.sv
package dcache_pkg;

  // cache geometry
  localparam int line_bits = 128;
  localparam int off_bits  = 4;                // byte offset within a line
  localparam int idx_bits  = 6;
  localparam int addr_bits = 32;
  localparam int tag_bits  = addr_bits - idx_bits - off_bits;
  localparam int num_ways  = 2;
  localparam int data_bits = 64;
  localparam int num_sets  = 1 << idx_bits;

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] index;
    logic [off_bits-1:0] offset;
  } addr_t;

  // access size, same encoding as the store select of the data array
  typedef enum logic [1:0] {
    sz_byte  = 2'b00,
    sz_half  = 2'b01,
    sz_word  = 2'b10,
    sz_dword = 2'b11
  } size_e;

  typedef struct packed {
    logic                 is_store;
    size_e                size;
    logic                 is_signed;   // load extension, ignored for stores
    addr_t                addr;
    logic [data_bits-1:0] data;        // store data, right aligned
  } req_t;

  // one cache line, seen at every access width
  typedef union packed {
    logic [15:0][7:0]  bytes;
    logic [7:0][15:0]  halves;
    logic [3:0][31:0]  words;
    logic [1:0][63:0]  dwords;
  } line_u;

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [idx_bits-1:0] index;
  } mem_rd_t;

  typedef struct packed {
    addr_t                addr;
    size_e                size;
    logic [data_bits-1:0] data;
  } mem_wr_t;

  typedef struct packed {
    logic                fill;         // whole line from memory
    logic                store;        // sized merge at offset
    logic [idx_bits-1:0] index;
    logic [tag_bits-1:0] tag;
    size_e               size;
    logic [off_bits-1:0] offset;
    line_u               line;
  } way_wr_t;

  typedef struct packed {
    logic [data_bits-1:0] data;
  } resp_t;

endpackage

// File: src/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array (
  input  logic                              clk,
  input  logic                              wr_en,
  input  logic                              fill,
  input  logic [dcache_pkg::idx_bits-1:0]   index,
  input  dcache_pkg::size_e                 size,
  input  logic [dcache_pkg::off_bits-1:0]   offset,
  input  dcache_pkg::line_u                 wr_data,
  output dcache_pkg::line_u                 rd_line
);

  dcache_pkg::line_u lines [dcache_pkg::num_sets];
  dcache_pkg::line_u merged;

  // read is combinational at index
  assign rd_line = lines[index];

  // store data sits in the low bits of wr_data, placed by size and offset
  always_comb begin
    merged = rd_line;
    unique case (size)
      dcache_pkg::sz_byte: begin
        merged.bytes[offset] = wr_data.bytes[0];
      end
      dcache_pkg::sz_half: begin
        merged.halves[offset[3:1]] = wr_data.halves[0];  // offset[0] ignored
      end
      dcache_pkg::sz_word: begin
        merged.words[offset[3:2]] = wr_data.words[0];
      end
      dcache_pkg::sz_dword: begin
        merged.dwords[offset[3]] = wr_data.dwords[0];
      end
      default: begin
        merged = rd_line;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (fill) begin
        lines[index] <= wr_data;                 // refill replaces the line
      end else begin
        lines[index] <= merged;
      end
    end
  end

endmodule

// File: src/dcache_way.sv
`timescale 1ns/100ps

module dcache_way (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [dcache_pkg::idx_bits-1:0]   rd_index,
  input  logic [dcache_pkg::tag_bits-1:0]   rd_tag,
  input  dcache_pkg::way_wr_t               wr,
  input  logic                              wr_sel,
  output logic                              hit,
  output dcache_pkg::line_u                 rd_line
);

  logic [dcache_pkg::tag_bits-1:0] tags [dcache_pkg::num_sets];
  logic [dcache_pkg::num_sets-1:0] valid;
  logic                            wr_en;
  logic [dcache_pkg::idx_bits-1:0] arr_index;

  assign wr_en     = wr_sel & (wr.fill | wr.store);
  assign arr_index = wr_en ? wr.index : rd_index;

  // tags are written on refill
  always_ff @(posedge clk) begin
    if (wr_sel && wr.fill) begin
      tags[wr.index] <= wr.tag;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (wr_sel && wr.fill) begin
      valid[wr.index] <= 1'b1;
    end
  end

  assign hit = valid[rd_index] && (tags[rd_index] == rd_tag);

  dcache_data_array data_array_inst (
    .clk     (clk),
    .wr_en   (wr_en),
    .fill    (wr.fill),
    .index   (arr_index),
    .size    (wr.size),
    .offset  (wr.offset),
    .wr_data (wr.line),
    .rd_line (rd_line)
  );

endmodule

// File: src/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req_valid,
  input  dcache_pkg::req_t                  req,
  output logic                              req_ready,
  input  logic [dcache_pkg::num_ways-1:0]   way_hit,
  output logic [dcache_pkg::idx_bits-1:0]   rd_index,
  output logic [dcache_pkg::tag_bits-1:0]   rd_tag,
  output dcache_pkg::way_wr_t               way_wr,
  output logic [dcache_pkg::num_ways-1:0]   way_sel,
  output logic                              mem_rd_valid,
  input  logic                              mem_rd_ready,
  output dcache_pkg::mem_rd_t               mem_rd,
  input  logic                              mem_line_valid,
  input  dcache_pkg::line_u                 mem_line,
  output logic                              mem_wr_valid,
  input  logic                              mem_wr_ready,
  output dcache_pkg::mem_wr_t               mem_wr,
  output logic                              done,
  output dcache_pkg::req_t                  cur_req
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_miss_req,
    st_miss_wait,
    st_store_wr,
    st_finish
  } state_e;

  state_e                          state, state_nxt;
  logic [dcache_pkg::num_sets-1:0] lru;       // way to replace next
  logic                            any_hit;
  logic                            hit_way;
  logic                            fill_way;
  logic                            fill_en;
  logic                            store_en;

  assign req_ready = (state == st_idle);
  assign rd_index  = cur_req.addr.index;
  assign rd_tag    = cur_req.addr.tag;
  assign any_hit   = |way_hit;
  assign fill_way  = lru[cur_req.addr.index];

  always_comb begin
    hit_way = 1'b0;
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      if (way_hit[w]) begin
        hit_way = 1'(w);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      cur_req <= req;
    end
  end

  always_comb begin
    state_nxt    = state;
    done         = 1'b0;
    store_en     = 1'b0;
    fill_en      = 1'b0;
    mem_rd_valid = 1'b0;
    mem_wr_valid = 1'b0;
    unique case (state)
      st_idle: begin
        if (req_valid) state_nxt = st_lookup;
      end
      st_lookup: begin
        if (cur_req.is_store) begin
          store_en     = any_hit;                // write through, no allocate
          mem_wr_valid = 1'b1;
          done         = mem_wr_ready;
          state_nxt    = mem_wr_ready ? st_finish : st_store_wr;
        end else if (any_hit) begin
          done      = 1'b1;
          state_nxt = st_finish;
        end else begin
          mem_rd_valid = 1'b1;
          state_nxt    = mem_rd_ready ? st_miss_wait : st_miss_req;
        end
      end
      st_miss_req: begin
        mem_rd_valid = 1'b1;
        if (mem_rd_ready) state_nxt = st_miss_wait;
      end
      st_miss_wait: begin
        fill_en = mem_line_valid;
        if (mem_line_valid) state_nxt = st_lookup;  // re-read after refill
      end
      st_store_wr: begin
        mem_wr_valid = 1'b1;
        done         = mem_wr_ready;
        if (mem_wr_ready) state_nxt = st_finish;
      end
      st_finish: begin
        state_nxt = st_idle;                     // resp_valid is high here
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lru <= '0;
    end else if (fill_en) begin
      lru[cur_req.addr.index] <= ~fill_way;
    end else if (state == st_lookup && any_hit) begin
      lru[cur_req.addr.index] <= ~hit_way;
    end
  end

  always_comb begin
    way_wr.fill   = fill_en;
    way_wr.store  = store_en;
    way_wr.index  = cur_req.addr.index;
    way_wr.tag    = cur_req.addr.tag;
    way_wr.size   = cur_req.size;
    way_wr.offset = cur_req.addr.offset;
    if (fill_en) begin
      way_wr.line = mem_line;
    end else begin
      way_wr.line.dwords[1] = '0;
      way_wr.line.dwords[0] = cur_req.data;
    end
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      way_sel[w] = fill_en ? (fill_way == 1'(w)) : (store_en & way_hit[w]);
    end
  end

  assign mem_rd.tag   = cur_req.addr.tag;
  assign mem_rd.index = cur_req.addr.index;
  assign mem_wr.addr  = cur_req.addr;
  assign mem_wr.size  = cur_req.size;
  assign mem_wr.data  = cur_req.data;

endmodule

// File: src/dcache_resp.sv
`timescale 1ns/100ps

module dcache_resp (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        done,
  input  dcache_pkg::req_t                            cur_req,
  input  logic [dcache_pkg::num_ways-1:0]             way_hit,
  input  dcache_pkg::line_u [dcache_pkg::num_ways-1:0] way_line,
  output logic                                        resp_valid,
  output dcache_pkg::resp_t                           resp
);

  dcache_pkg::line_u               sel_line;
  logic [7:0]                      ld_byte;
  logic [15:0]                     ld_half;
  logic [31:0]                     ld_word;
  logic [dcache_pkg::data_bits-1:0] ld_data;
  logic                            sgn;

  always_comb begin
    sel_line = '0;
    for (int w = 0; w < dcache_pkg::num_ways; w++) begin
      if (way_hit[w]) sel_line = way_line[w];
    end
  end

  assign sgn     = cur_req.is_signed;
  assign ld_byte = sel_line.bytes[cur_req.addr.offset];
  assign ld_half = sel_line.halves[cur_req.addr.offset[3:1]];
  assign ld_word = sel_line.words[cur_req.addr.offset[3:2]];

  // extend the sized field to 64 bits
  always_comb begin
    unique case (cur_req.size)
      dcache_pkg::sz_byte:  ld_data = {{56{sgn & ld_byte[7]}}, ld_byte};
      dcache_pkg::sz_half:  ld_data = {{48{sgn & ld_half[15]}}, ld_half};
      dcache_pkg::sz_word:  ld_data = {{32{sgn & ld_word[31]}}, ld_word};
      dcache_pkg::sz_dword: ld_data = sel_line.dwords[cur_req.addr.offset[3]];
      default:              ld_data = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= done;                        // one-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      resp.data <= cur_req.is_store ? '0 : ld_data;
    end
  end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/100ps

module dcache_top (
  input  logic                clk,
  input  logic                arst_n,
  // cpu side
  input  logic                req_valid,
  output logic                req_ready,
  input  dcache_pkg::req_t    req,
  output logic                resp_valid,
  output dcache_pkg::resp_t   resp,
  // memory line read
  output logic                mem_rd_valid,
  input  logic                mem_rd_ready,
  output dcache_pkg::mem_rd_t mem_rd,
  input  logic                mem_line_valid,
  input  dcache_pkg::line_u   mem_line,
  // memory write through
  output logic                mem_wr_valid,
  input  logic                mem_wr_ready,
  output dcache_pkg::mem_wr_t mem_wr
);

  logic [dcache_pkg::num_ways-1:0]              way_hit;
  logic [dcache_pkg::num_ways-1:0]              way_sel;
  dcache_pkg::line_u [dcache_pkg::num_ways-1:0] way_line;
  dcache_pkg::way_wr_t                          way_wr;
  logic [dcache_pkg::idx_bits-1:0]              rd_index;
  logic [dcache_pkg::tag_bits-1:0]              rd_tag;
  logic                                         done;
  dcache_pkg::req_t                             cur_req;

  dcache_ctrl ctrl_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req            (req),
    .req_ready      (req_ready),
    .way_hit        (way_hit),
    .rd_index       (rd_index),
    .rd_tag         (rd_tag),
    .way_wr         (way_wr),
    .way_sel        (way_sel),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_ready   (mem_rd_ready),
    .mem_rd         (mem_rd),
    .mem_line_valid (mem_line_valid),
    .mem_line       (mem_line),
    .mem_wr_valid   (mem_wr_valid),
    .mem_wr_ready   (mem_wr_ready),
    .mem_wr         (mem_wr),
    .done           (done),
    .cur_req        (cur_req)
  );

  for (genvar g = 0; g < dcache_pkg::num_ways; g++) begin : g_way
    dcache_way way_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd_index (rd_index),
      .rd_tag   (rd_tag),
      .wr       (way_wr),
      .wr_sel   (way_sel[g]),
      .hit      (way_hit[g]),
      .rd_line  (way_line[g])
    );
  end

  dcache_resp resp_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .done       (done),
    .cur_req    (cur_req),
    .way_hit    (way_hit),
    .way_line   (way_line),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

// File: tb/mem_model.sv
`timescale 1ns/100ps

module mem_model (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_rd_valid,
  output logic                mem_rd_ready,
  input  dcache_pkg::mem_rd_t mem_rd,
  output logic                mem_line_valid,
  output dcache_pkg::line_u   mem_line,
  input  logic                mem_wr_valid,
  output logic                mem_wr_ready,
  input  dcache_pkg::mem_wr_t mem_wr,
  output int                  rd_count,         // accepted line reads
  output dcache_pkg::mem_rd_t last_rd,
  output int                  wr_count,         // accepted writes
  output dcache_pkg::mem_wr_t last_wr
);

  logic [7:0]          written [logic [31:0]];  // bytes changed by writes
  logic                busy;
  int                  wait_cnt;
  dcache_pkg::mem_rd_t rd_addr;

  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;                      // every address bit reaches the top byte
    return h[31:24];
  endfunction

  function automatic logic [7:0] read_byte(input logic [31:0] a);
    if (written.exists(a)) begin
      return written[a];
    end
    return pattern_byte(a);
  endfunction

  // valid does not depend on ready in the cache, so a handshake is known at the falling edge
  initial begin
    mem_rd_ready   = 1'b0;
    mem_wr_ready   = 1'b0;
    mem_line_valid = 1'b0;
    mem_line       = '0;
    rd_count       = 0;
    wr_count       = 0;
    last_rd        = '0;
    last_wr        = '0;
    busy           = 1'b0;
    wait_cnt       = 0;
    forever begin
      @(negedge clk);
      mem_line_valid = 1'b0;
      if (!arst_n) begin
        mem_rd_ready = 1'b0;
        mem_wr_ready = 1'b0;
        busy         = 1'b0;
      end else begin
        if (busy) begin
          wait_cnt--;
          if (wait_cnt == 0) begin
            busy           = 1'b0;
            mem_line_valid = 1'b1;
            for (int i = 0; i < 16; i++) begin
              mem_line.bytes[i] = read_byte({rd_addr, 4'(i)});
            end
          end
        end
        mem_rd_ready = !busy && ($urandom % 4 != 0);  // occasional stall
        if (mem_rd_valid && mem_rd_ready) begin
          busy     = 1'b1;                             // taken at the next rising edge
          rd_addr  = mem_rd;
          last_rd  = mem_rd;
          wait_cnt = 1 + int'($urandom % 8);
          rd_count++;
        end
        mem_wr_ready = ($urandom % 3 != 0);
        if (mem_wr_valid && mem_wr_ready) begin
          for (int i = 0; i < (1 << int'(mem_wr.size)); i++) begin
            written[32'(mem_wr.addr) + 32'(i)] = mem_wr.data[8*i +: 8];
          end
          last_wr = mem_wr;
          wr_count++;
        end
      end
    end
  end

endmodule

// File: tb/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

  localparam int max_cycles = 400 * 40;      // transactions times worst-case latency

  logic                clk;
  logic                arst_n;
  logic                req_valid;
  logic                req_ready;
  dcache_pkg::req_t    req;
  logic                resp_valid;
  dcache_pkg::resp_t   resp;
  logic                mem_rd_valid;
  logic                mem_rd_ready;
  dcache_pkg::mem_rd_t mem_rd;
  logic                mem_line_valid;
  dcache_pkg::line_u   mem_line;
  logic                mem_wr_valid;
  logic                mem_wr_ready;
  dcache_pkg::mem_wr_t mem_wr;
  int                  rd_count;
  int                  wr_count;
  dcache_pkg::mem_rd_t last_rd;
  dcache_pkg::mem_wr_t last_wr;

  // reference model
  logic [7:0]  shadow [logic [31:0]];
  logic [21:0] ref_tag [64][2];
  logic [1:0]  ref_valid [64];
  logic        ref_lru [64];                 // way to replace next

  int errors;
  int tests;
  int failed_tests;
  int cycles;

  dcache_top dcache_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req            (req),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_ready   (mem_rd_ready),
    .mem_rd         (mem_rd),
    .mem_line_valid (mem_line_valid),
    .mem_line       (mem_line),
    .mem_wr_valid   (mem_wr_valid),
    .mem_wr_ready   (mem_wr_ready),
    .mem_wr         (mem_wr)
  );

  mem_model mem_model_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .mem_rd_valid   (mem_rd_valid),
    .mem_rd_ready   (mem_rd_ready),
    .mem_rd         (mem_rd),
    .mem_line_valid (mem_line_valid),
    .mem_line       (mem_line),
    .mem_wr_valid   (mem_wr_valid),
    .mem_wr_ready   (mem_wr_ready),
    .mem_wr         (mem_wr),
    .rd_count       (rd_count),
    .last_rd        (last_rd),
    .wr_count       (wr_count),
    .last_wr        (last_wr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles", cycles);
    $display("tests failed");
    $finish;
  end

  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9e37_79b1;                   // same fill as the memory model
    return h[31:24];
  endfunction

  function automatic logic [7:0] shadow_byte(input logic [31:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return pattern_byte(a);
  endfunction

  // little endian field extended by size and signedness
  function automatic logic [63:0] expect_load(input logic [31:0] a, input int n,
                                              input logic sgn);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = shadow_byte(a + 32'(i));
    end
    if (sgn && v[8*n-1]) begin
      for (int i = n; i < 8; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  // hit or miss before the access, then tags and LRU as the cache updates them
  function automatic logic predict_hit(input logic [31:0] a, input logic st);
    logic [5:0]  idx;
    logic [21:0] tag;
    logic        hit;
    int          way;
    idx = a[9:4];
    tag = a[31:10];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < 2; w++) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit && !st) begin
      way = int'(ref_lru[idx]);              // loads allocate, stores do not
      ref_valid[idx][way] = 1'b1;
      ref_tag[idx][way]   = tag;
    end
    if (hit || !st) begin
      ref_lru[idx] = (way == 0);
    end
    return hit;
  endfunction

  function automatic dcache_pkg::req_t make_req(input logic st, input logic [1:0] sz,
                                                input logic sgn, input logic [31:0] a,
                                                input logic [63:0] d);
    dcache_pkg::req_t r;
    r.is_store  = st;
    r.size      = dcache_pkg::size_e'(sz);
    r.is_signed = sgn;
    r.addr      = a & ~((32'd1 << sz) - 32'd1);   // keep accesses aligned
    r.data      = d;
    return r;
  endfunction

  task automatic report_err(input string name, input string what,
                            input logic [127:0] exp, input logic [127:0] act);
    $display("ERR %s %s: expected %0h actual %0h", name, what, exp, act);
    errors++;
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors != e0) begin
      failed_tests++;
    end
    $display("%s: %s, %0d errors", name, (errors == e0) ? "ok" : "FAIL", errors - e0);
  endtask

  task automatic run_access(input string name, input dcache_pkg::req_t r, output logic missed);
    logic [31:0]         a;
    logic                exp_hit;
    logic [63:0]         exp_data;
    dcache_pkg::mem_wr_t exp_wr;
    int                  n;
    int                  exp_reads;
    int                  lat;
    int                  rd0;
    int                  wr0;
    a         = r.addr;
    n         = 1 << int'(r.size);
    exp_hit   = predict_hit(a, r.is_store);
    exp_data  = r.is_store ? 64'd0 : expect_load(a, n, r.is_signed);
    exp_reads = (exp_hit || r.is_store) ? 0 : 1;
    exp_wr    = {a, r.size, r.data};
    if (r.is_store) begin
      for (int i = 0; i < n; i++) begin
        shadow[a + 32'(i)] = r.data[8*i +: 8];
      end
    end
    rd0 = rd_count;
    wr0 = wr_count;
    @(negedge clk);
    req       = r;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);                          // accepted at the rising edge just passed
    req_valid = 1'b0;
    lat       = 1;
    while (!resp_valid && lat < 40) begin
      @(negedge clk);
      lat++;
    end
    missed = (rd_count != rd0);
    if (!resp_valid) begin
      $display("%s: no response within %0d cycles of acceptance", name, lat);
      errors++;
      return;
    end
    if (resp.data !== exp_data) report_err(name, "data", exp_data, resp.data);
    if (rd_count - rd0 != exp_reads) report_err(name, "line reads", exp_reads, rd_count - rd0);
    if (exp_reads == 1 && last_rd !== a[31:4]) report_err(name, "read line", a[31:4], last_rd);
    if (wr_count - wr0 != int'(r.is_store)) begin
      report_err(name, "writes", r.is_store, wr_count - wr0);
    end
    if (r.is_store && last_wr !== exp_wr) report_err(name, "write", exp_wr, last_wr);
    if (!r.is_store && exp_hit && lat != 2) report_err(name, "hit latency", 2, lat);
  endtask

  task automatic check_reset_state();
    int   e0;
    logic missed;
    e0 = errors;
    @(negedge clk);
    if (req_ready !== 1'b1) report_err("reset state", "req_ready", 1, req_ready);
    if (resp_valid !== 1'b0) report_err("reset state", "resp_valid", 0, resp_valid);
    if (mem_rd_valid !== 1'b0) report_err("reset state", "mem_rd_valid", 0, mem_rd_valid);
    if (mem_wr_valid !== 1'b0) report_err("reset state", "mem_wr_valid", 0, mem_wr_valid);
    run_access("reset state", make_req(1'b0, 2'd3, 1'b0, 32'h0000_1230, '0), missed);
    if (!missed) begin
      $display("reset state: first load after reset did not read memory");
      errors++;
    end
    report_test("reset state", e0);
  endtask

  task automatic check_miss_then_hit();
    int   e0;
    logic missed;
    e0 = errors;
    run_access("miss then hit", make_req(1'b0, 2'd3, 1'b0, 32'h0004_5670, '0), missed);
    if (!missed) begin
      $display("miss then hit: load of a new line did not read memory");
      errors++;
    end
    run_access("miss then hit", make_req(1'b0, 2'd2, 1'b1, 32'h0004_567c, '0), missed);
    if (missed) begin
      $display("miss then hit: load of a cached line read memory");
      errors++;
    end
    report_test("miss then hit", e0);
  endtask

  task automatic load_every_size();
    int   e0;
    logic missed;
    e0 = errors;
    run_access("load extraction", make_req(1'b0, 2'd0, 1'b0, 32'h0010_0a40, '0), missed);
    for (int sz = 0; sz < 4; sz++) begin
      for (int sgn = 0; sgn < 2; sgn++) begin
        for (int off = 0; off < 16; off += 1 << sz) begin
          run_access("load extraction",
                     make_req(1'b0, 2'(sz), 1'(sgn), 32'h0010_0a40 + 32'(off), '0), missed);
        end
      end
    end
    report_test("load extraction", e0);
  endtask

  task automatic store_every_size();
    int          e0;
    logic        missed;
    logic [31:0] a;
    logic [63:0] d;
    e0 = errors;
    run_access("sized stores", make_req(1'b0, 2'd3, 1'b0, 32'h0020_0b80, '0), missed);
    for (int sz = 0; sz < 4; sz++) begin
      d = {$urandom, $urandom};
      a = 32'h0020_0b80 + 32'(sz * 5);
      run_access("sized stores", make_req(1'b1, 2'(sz), 1'b0, a, d), missed);
      run_access("sized stores", make_req(1'b0, 2'(sz), 1'b0, a, '0), missed);
      if (missed) begin
        $display("sized stores: load after a store hit read memory");
        errors++;
      end
      a = 32'h0030_0c00 + 32'(sz * 16);      // lines not cached yet
      run_access("sized stores", make_req(1'b1, 2'(sz), 1'b0, a, d), missed);
      run_access("sized stores", make_req(1'b0, 2'(sz), 1'b0, a, '0), missed);
      if (!missed) begin
        $display("sized stores: a store miss allocated a line");
        errors++;
      end
    end
    report_test("sized stores", e0);
  endtask

  task automatic replace_lru();
    int               e0;
    logic             missed;
    logic [5:0]       exp_miss;
    logic [5:0][21:0] tag_seq;
    e0       = errors;
    exp_miss = 6'b101011;                    // bit i for access i
    tag_seq  = {22'h102, 22'h101, 22'h103, 22'h101, 22'h102, 22'h101};
    for (int i = 0; i < 6; i++) begin
      run_access("lru replacement",
                 make_req(1'b0, 2'd3, 1'b0, {tag_seq[i], 6'h15, 4'h0}, '0), missed);
      if (missed !== exp_miss[i]) begin
        $display("lru replacement: access %0d to tag %0h has the wrong hit or miss",
                 i, tag_seq[i]);
        errors++;
      end
    end
    report_test("lru replacement", e0);
  endtask

  task automatic random_mix();
    int          e0;
    logic        missed;
    logic        st;
    logic [31:0] a;
    logic [63:0] d;
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      a  = {20'd0, 2'($urandom % 3), 6'($urandom % 4), 4'($urandom % 16)};
      st = ($urandom % 3 == 0);
      d  = {$urandom, $urandom};
      run_access("random mix", make_req(st, 2'($urandom % 4), 1'($urandom % 2), a, d), missed);
    end
    report_test("random mix", e0);
  endtask

  initial begin
    void'($urandom(32'h163d_bdf9));
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    arst_n       = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    for (int s = 0; s < 64; s++) begin
      ref_valid[s] = '0;
      ref_lru[s]   = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_reset_state();
    check_miss_then_hit();
    load_every_size();
    store_every_size();
    replace_lru();
    random_mix();
    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
src/dcache_pkg.sv
src/dcache_data_array.sv
src/dcache_way.sv
src/dcache_ctrl.sv
src/dcache_resp.sv
src/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     ?= dcache_tb
RTL_TOP    ?= dcache_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --timing -Wall
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG); cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
